// File: flist.f
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/processor.sv
sim/tb_processor.sv

// File: Bender.yml
package:
  name: pipelined_processor

sources:
  - verilog/cpu_pkg.sv
  - verilog/fetch_stage.sv
  - verilog/decode_stage.sv
  - verilog/execute_stage.sv
  - verilog/memory_stage.sv
  - verilog/processor.sv
  - target: simulation
    files:
      - sim/tb_processor.sv

// File: sim/tb_processor.sv
`default_nettype none

module tb_processor;
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_pkg::*;

  logic                      clk = 1'b1;
  logic                      rst_n;
  logic                      prog_we;
  logic [ADDR_WIDTH-1:0]     prog_addr;
  logic [INST_WIDTH-1:0]     prog_data;
  logic                      wb_en;
  logic [REG_ADDR_WIDTH-1:0] wb_reg;
  logic [DATA_WIDTH-1:0]     wb_data;
  logic                      dmem_we;
  logic [ADDR_WIDTH-1:0]     dmem_addr;
  logic [DATA_WIDTH-1:0]     dmem_wdata;

  // program image and reference model state
  logic [INST_WIDTH-1:0]     prog [IMEM_DEPTH];
  logic [DATA_WIDTH-1:0]     model_regs [2**REG_ADDR_WIDTH];
  logic [DATA_WIDTH-1:0]     model_mem [DMEM_DEPTH];

  // expected retirements in program order
  logic [REG_ADDR_WIDTH-1:0] exp_wb_reg [$];
  logic [DATA_WIDTH-1:0]     exp_wb_data [$];
  logic [ADDR_WIDTH-1:0]     exp_st_addr [$];
  logic [DATA_WIDTH-1:0]     exp_st_data [$];

  int run_cycles   = 0;
  int reset_cycles = 0;
  int cycle_limit  = 1000;
  int wb_checked   = 0;
  int st_checked   = 0;

  processor DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .wb_en      (wb_en),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data),
    .dmem_we    (dmem_we),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
    abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  function automatic logic [INST_WIDTH-1:0] r_type(input opcode_e op,
      input logic [2:0] rs, input logic [2:0] rt, input logic [2:0] rd);
    return {op, rs, rt, rd, 3'b000};
  endfunction

  function automatic logic [INST_WIDTH-1:0] i_type(input opcode_e op,
      input logic [2:0] rs, input logic [2:0] rt, input logic [5:0] imm);
    return {op, rs, rt, imm};
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  task automatic record_writeback(input logic [2:0] dest, input logic [15:0] value);
    if (dest != 3'd0) begin
      model_regs[dest] = value;
      exp_wb_reg.push_back(dest);
      exp_wb_data.push_back(value);
    end
  endtask

  // runs until the j that targets itself
  task automatic run_model();
    int pc;
    int next_pc;
    int steps;
    logic [15:0] ins;
    opcode_e op;
    logic [2:0] rs, rt, rd;
    logic [5:0] imm;
    logic [15:0] a, b, sum;
    logic done;
    pc = 0;
    steps = 0;
    done = 1'b0;
    while (!done) begin
      ins = prog[pc];
      op = opcode_e'(ins[15:12]);
      rs = ins[11:9];
      rt = ins[8:6];
      rd = ins[5:3];
      imm = ins[5:0];
      a = model_regs[rs];
      b = model_regs[rt];
      sum = a + {10'b0, imm};
      next_pc = pc + 1;
      case (op)
        op_add:  record_writeback(rd, a + b);
        op_sub:  record_writeback(rd, a - b);
        op_and:  record_writeback(rd, a & b);
        op_or:   record_writeback(rd, a | b);
        op_slt:  record_writeback(rd, (a < b) ? 16'd1 : 16'd0);
        op_addi: record_writeback(rt, sum);
        op_lw:   record_writeback(rt, model_mem[sum[5:0]]);
        op_sw: begin
          model_mem[sum[5:0]] = b;
          exp_st_addr.push_back(sum[5:0]);
          exp_st_data.push_back(b);
        end
        op_beq: if (a == b) next_pc = imm;
        op_bne: if (a != b) next_pc = imm;
        op_j: begin
          if (imm == pc) done = 1'b1;
          next_pc = imm;
        end
        default: ;
      endcase
      pc = next_pc;
      steps++;
      if (steps > 256) begin
        abort_run("reference model never reached the final self-loop");
      end
    end
  endtask

  //////////////////////////////
  // programs
  //////////////////////////////

  task automatic build_directed();
    prog[0]  = i_type(op_addi, 3'd0, 3'd1, 6'd3);
    prog[1]  = i_type(op_addi, 3'd0, 3'd2, 6'd12);
    prog[2]  = r_type(op_add,  3'd1, 3'd2, 3'd3);
    prog[3]  = r_type(op_sub,  3'd3, 3'd1, 3'd4);
    prog[4]  = r_type(op_slt,  3'd4, 3'd3, 3'd5);
    prog[5]  = i_type(op_sw,   3'd1, 3'd3, 6'd2);
    prog[6]  = i_type(op_lw,   3'd1, 3'd6, 6'd2);
    // load-use stall
    prog[7]  = r_type(op_add,  3'd6, 3'd5, 3'd7);
    prog[8]  = i_type(op_beq,  3'd7, 3'd6, 6'd15);
    // two-pass loop on r5, backward bne taken once
    prog[9]  = i_type(op_addi, 3'd5, 3'd5, 6'd1);
    prog[10] = i_type(op_bne,  3'd5, 3'd1, 6'd9);
    prog[11] = i_type(op_beq,  3'd4, 3'd2, 6'd13);
    prog[12] = i_type(op_addi, 3'd0, 3'd2, 6'd63);
    prog[13] = i_type(op_j,    3'd0, 3'd0, 6'd15);
    prog[14] = i_type(op_sw,   3'd0, 3'd7, 6'd0);
    prog[15] = i_type(op_j,    3'd0, 3'd0, 6'd15);
  endtask

  task automatic build_random();
    int i;
    int sel;
    for (i = 0; i < 15; i++) begin
      sel = $urandom % 6;
      if (sel == 5) begin
        prog[i] = i_type(op_addi, 3'($urandom % 8), 3'($urandom % 8), 6'($urandom % 64));
      end else begin
        prog[i] = r_type(opcode_e'(sel + 1), 3'($urandom % 8), 3'($urandom % 8),
                         3'($urandom % 8));
      end
    end
    prog[15] = i_type(op_j, 3'd0, 3'd0, 6'd15);
  endtask

  // program words go in on falling edges while the core is held in reset
  task automatic reset_and_load(input int len);
    int i;
    for (i = 0; i < 16; i++) begin
      @(negedge clk);
      rst_n     = 1'b0;
      prog_we   = (i < len);
      prog_addr = ADDR_WIDTH'(i);
      prog_data = prog[i];
    end
    @(negedge clk);
    prog_we = 1'b0;
    rst_n   = 1'b1;
  endtask

  task automatic run_program(input int len, input string name);
    run_model();
    cycle_limit = 4 * len + 40;
    reset_and_load(len);
    while (exp_wb_reg.size() != 0 || exp_st_addr.size() != 0) begin
      @(negedge clk);
    end
    // self-loop has to stay silent
    repeat (16) @(negedge clk);
    $display("%s program done, %0d writebacks and %0d stores checked so far",
             name, wb_checked, st_checked);
  endtask

  //////////////////////////////
  // checkers
  //////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      run_cycles   <= 0;
      reset_cycles <= reset_cycles + 1;
    end else begin
      run_cycles   <= run_cycles + 1;
      reset_cycles <= 0;
    end
  end

  always @(posedge clk) begin
    if (rst_n && run_cycles > cycle_limit) begin
      abort_run($sformatf("timeout, program not retired within %0d cycles", cycle_limit));
    end
  end

  always @(posedge clk) begin : check_writeback
    logic [REG_ADDR_WIDTH-1:0] exp_reg;
    logic [DATA_WIDTH-1:0]     exp_data;
    if (rst_n && wb_en !== 1'b0) begin
      if (exp_wb_reg.size() == 0) begin
        abort_run("writeback strobe with no retirement left in the reference model");
      end else begin
        exp_reg  = exp_wb_reg.pop_front();
        exp_data = exp_wb_data.pop_front();
        assert (wb_reg != '0) else report_mismatch("wb_reg", 16'(wb_reg), 16'(exp_reg));
        assert (wb_reg == exp_reg) else report_mismatch("wb_reg", 16'(wb_reg), 16'(exp_reg));
        assert (wb_data == exp_data) else report_mismatch("wb_data", wb_data, exp_data);
        wb_checked++;
      end
    end
  end

  always @(posedge clk) begin : check_store
    logic [ADDR_WIDTH-1:0] exp_addr;
    logic [DATA_WIDTH-1:0] exp_data;
    if (rst_n && dmem_we !== 1'b0) begin
      if (exp_st_addr.size() == 0) begin
        abort_run("store strobe with no store left in the reference model");
      end else begin
        exp_addr = exp_st_addr.pop_front();
        exp_data = exp_st_data.pop_front();
        assert (dmem_addr == exp_addr)
          else report_mismatch("dmem_addr", 16'(dmem_addr), 16'(exp_addr));
        assert (dmem_wdata == exp_data) else report_mismatch("dmem_wdata", dmem_wdata, exp_data);
        st_checked++;
      end
    end
  end

  // nothing retires in reset or before the first fetch can reach writeback
  a_quiet_after_reset: assert property (@(posedge clk)
    ((!rst_n && reset_cycles != 0) || (rst_n && run_cycles < 3)) |-> (!wb_en && !dmem_we))
    else abort_run("strobe seen in reset or in the first cycles after its release");

  initial begin
    void'($urandom(32'h2f872a21));
    rst_n         = 1'b0;
    prog_we       = 1'b0;
    prog_addr     = '0;
    prog_data     = '0;
    model_regs[0] = '0;
    build_directed();
    run_program(16, "directed");
    build_random();
    run_program(16, "random");
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/processor.sv
`default_nettype none

module processor (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               prog_we,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0]     prog_addr,
  input  logic [cpu_pkg::INST_WIDTH-1:0]     prog_data,
  output logic                               wb_en,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] wb_reg,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     wb_data,
  output logic                               dmem_we,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]     dmem_addr,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     dmem_wdata
);
  import cpu_pkg::*;

  // hazard and redirect
  logic                  stall;
  logic                  jump_taken;
  logic [ADDR_WIDTH-1:0] jump_target;
  logic                  flush;
  logic [ADDR_WIDTH-1:0] branch_target;

  // IF/ID
  logic [INST_WIDTH-1:0] if_id_instr;
  logic [ADDR_WIDTH-1:0] if_id_pc;

  // ID/EX
  logic [REG_ADDR_WIDTH-1:0] id_ex_rs, id_ex_rt, id_ex_rd;
  logic [DATA_WIDTH-1:0]     id_ex_rs_data, id_ex_rt_data;
  logic [IMM_WIDTH-1:0]      id_ex_imm;
  alu_op_e                   id_ex_alu_op;
  logic id_ex_alu_src, id_ex_reg_dst, id_ex_reg_write;
  logic id_ex_mem_read, id_ex_mem_write, id_ex_is_beq, id_ex_is_bne;

  // EX/MEM
  logic [DATA_WIDTH-1:0]     ex_mem_alu_result, ex_mem_store_data;
  logic [REG_ADDR_WIDTH-1:0] ex_mem_dest;
  logic [ADDR_WIDTH-1:0]     ex_mem_target;
  logic ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write;
  logic ex_mem_is_beq, ex_mem_is_bne, ex_mem_equal;

  // stage ports share the names of the pipeline signals above
  fetch_stage u_fetch (.*);

  decode_stage u_decode (.*);

  execute_stage u_execute (.*);

  memory_stage u_memory (.*);

endmodule

`default_nettype wire

// File: verilog/memory_stage.sv
`default_nettype none

module memory_stage (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     ex_mem_alu_result,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     ex_mem_store_data,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_mem_dest,
  input  logic                               ex_mem_reg_write,
  input  logic                               ex_mem_mem_read,
  input  logic                               ex_mem_mem_write,
  input  logic                               ex_mem_is_beq,
  input  logic                               ex_mem_is_bne,
  input  logic                               ex_mem_equal,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0]     ex_mem_target,
  output logic                               flush,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]     branch_target,
  output logic                               dmem_we,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]     dmem_addr,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     dmem_wdata,
  output logic                               wb_en,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] wb_reg,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     wb_data
);
  import cpu_pkg::*;

  logic [DATA_WIDTH-1:0] dmem [DMEM_DEPTH];
  logic [DATA_WIDTH-1:0] load_data;
  logic                  mem_wb_mem_read;
  logic [DATA_WIDTH-1:0] mem_wb_load_data;
  logic [DATA_WIDTH-1:0] mem_wb_alu_result;

  // low address bits only
  assign dmem_we    = ex_mem_mem_write;
  assign dmem_addr  = ex_mem_alu_result[ADDR_WIDTH-1:0];
  assign dmem_wdata = ex_mem_store_data;

  always_ff @(posedge clk) begin
    if (rst_n && dmem_we) begin
      dmem[dmem_addr] <= dmem_wdata;
    end
  end

  assign load_data = dmem[dmem_addr];

  // taken branch squashes the three younger instructions
  assign flush = (ex_mem_is_beq && ex_mem_equal) || (ex_mem_is_bne && !ex_mem_equal);
  assign branch_target = ex_mem_target;

  // MEM/WB register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_en           <= 1'b0;
      mem_wb_mem_read <= 1'b0;
    end else begin
      wb_en           <= ex_mem_reg_write;
      mem_wb_mem_read <= ex_mem_mem_read;
    end
  end

  always_ff @(posedge clk) begin
    wb_reg            <= ex_mem_dest;
    mem_wb_load_data  <= load_data;
    mem_wb_alu_result <= ex_mem_alu_result;
  end

  assign wb_data = mem_wb_mem_read ? mem_wb_load_data : mem_wb_alu_result;

  a_flush_one_branch: assert property (@(posedge clk) disable iff (!rst_n)
    flush |-> (ex_mem_is_beq ^ ex_mem_is_bne));

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`default_nettype none

module execute_stage (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               flush,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] id_ex_rs,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] id_ex_rt,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] id_ex_rd,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     id_ex_rs_data,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     id_ex_rt_data,
  input  logic [cpu_pkg::IMM_WIDTH-1:0]      id_ex_imm,
  input  cpu_pkg::alu_op_e                   id_ex_alu_op,
  input  logic                               id_ex_alu_src,
  input  logic                               id_ex_reg_dst,
  input  logic                               id_ex_reg_write,
  input  logic                               id_ex_mem_read,
  input  logic                               id_ex_mem_write,
  input  logic                               id_ex_is_beq,
  input  logic                               id_ex_is_bne,
  input  logic                               wb_en,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] wb_reg,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     wb_data,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     ex_mem_alu_result,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     ex_mem_store_data,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] ex_mem_dest,
  output logic                               ex_mem_reg_write,
  output logic                               ex_mem_mem_read,
  output logic                               ex_mem_mem_write,
  output logic                               ex_mem_is_beq,
  output logic                               ex_mem_is_bne,
  output logic                               ex_mem_equal,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]     ex_mem_target
);
  import cpu_pkg::*;

  logic [DATA_WIDTH-1:0]     op_a;
  logic [DATA_WIDTH-1:0]     op_b;
  logic [DATA_WIDTH-1:0]     alu_b;
  logic [DATA_WIDTH-1:0]     alu_result;
  logic [REG_ADDR_WIDTH-1:0] dest;

  //////////////////////////////
  // forwarding
  //////////////////////////////

  // EX/MEM is the newer producer, then MEM/WB
  function automatic logic [DATA_WIDTH-1:0] forward_operand(
    input logic [REG_ADDR_WIDTH-1:0] src,
    input logic [DATA_WIDTH-1:0]     reg_value
  );
    if (src == '0) begin
      return reg_value;
    end else if (ex_mem_reg_write && ex_mem_dest == src) begin
      return ex_mem_alu_result;
    end else if (wb_en && wb_reg == src) begin
      return wb_data;
    end
    return reg_value;
  endfunction

  always_comb begin
    op_a = forward_operand(id_ex_rs, id_ex_rs_data);
    op_b = forward_operand(id_ex_rt, id_ex_rt_data);
  end

  assign alu_b = id_ex_alu_src ? {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, id_ex_imm} : op_b;

  always_comb begin
    case (id_ex_alu_op)
      alu_add: alu_result = op_a + alu_b;
      alu_sub: alu_result = op_a - alu_b;
      alu_and: alu_result = op_a & alu_b;
      alu_or:  alu_result = op_a | alu_b;
      // unsigned compare
      alu_slt: alu_result = {{(DATA_WIDTH-1){1'b0}}, (op_a < alu_b)};
      default: alu_result = '0;
    endcase
  end

  assign dest = id_ex_reg_dst ? id_ex_rd : id_ex_rt;

  //////////////////////////////
  // EX/MEM register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      ex_mem_reg_write <= 1'b0;
      ex_mem_mem_read  <= 1'b0;
      ex_mem_mem_write <= 1'b0;
      ex_mem_is_beq    <= 1'b0;
      ex_mem_is_bne    <= 1'b0;
    end else begin
      // r0 is never written, so drop the write here
      ex_mem_reg_write <= id_ex_reg_write && (dest != '0);
      ex_mem_mem_read  <= id_ex_mem_read;
      ex_mem_mem_write <= id_ex_mem_write;
      ex_mem_is_beq    <= id_ex_is_beq;
      ex_mem_is_bne    <= id_ex_is_bne;
    end
  end

  always_ff @(posedge clk) begin
    ex_mem_alu_result <= alu_result;
    ex_mem_store_data <= op_b;
    ex_mem_dest       <= dest;
    ex_mem_equal      <= (op_a == op_b);
    ex_mem_target     <= ADDR_WIDTH'(id_ex_imm);
  end

  a_mem_op_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    !(id_ex_mem_read && id_ex_mem_write));

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`default_nettype none

module decode_stage (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [cpu_pkg::INST_WIDTH-1:0]     if_id_instr,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0]     if_id_pc,
  input  logic                               flush,
  input  logic                               wb_en,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] wb_reg,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     wb_data,
  output logic                               stall,
  output logic                               jump_taken,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]     jump_target,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] id_ex_rs,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] id_ex_rt,
  output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] id_ex_rd,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     id_ex_rs_data,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     id_ex_rt_data,
  output logic [cpu_pkg::IMM_WIDTH-1:0]      id_ex_imm,
  output cpu_pkg::alu_op_e                   id_ex_alu_op,
  output logic                               id_ex_alu_src,
  output logic                               id_ex_reg_dst,
  output logic                               id_ex_reg_write,
  output logic                               id_ex_mem_read,
  output logic                               id_ex_mem_write,
  output logic                               id_ex_is_beq,
  output logic                               id_ex_is_bne
);
  import cpu_pkg::*;

  opcode_e                   opcode;
  logic [REG_ADDR_WIDTH-1:0] rs;
  logic [REG_ADDR_WIDTH-1:0] rt;
  logic [REG_ADDR_WIDTH-1:0] rd;
  logic [IMM_WIDTH-1:0]      imm;
  alu_op_e                   alu_op;
  logic alu_src, reg_dst, reg_write, mem_read, mem_write, is_beq, is_bne;
  logic uses_rs, uses_rt;
  logic [DATA_WIDTH-1:0]     regs [2**REG_ADDR_WIDTH];
  logic [DATA_WIDTH-1:0]     rs_data;
  logic [DATA_WIDTH-1:0]     rt_data;

  assign opcode      = opcode_e'(if_id_instr[15:12]);
  assign rs          = if_id_instr[11:9];
  assign rt          = if_id_instr[8:6];
  assign rd          = if_id_instr[5:3];
  assign imm         = if_id_instr[IMM_WIDTH-1:0];
  assign jump_target = ADDR_WIDTH'(imm);

  //////////////////////////////
  // control decode
  //////////////////////////////

  always_comb begin
    reg_dst    = 1'b0;
    alu_src    = 1'b0;
    reg_write  = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    is_beq     = 1'b0;
    is_bne     = 1'b0;
    jump_taken = 1'b0;
    uses_rs    = 1'b0;
    uses_rt    = 1'b0;
    case (opcode)
      op_add, op_sub, op_and, op_or, op_slt: begin
        reg_dst   = 1'b1;
        reg_write = 1'b1;
        uses_rs   = 1'b1;
        uses_rt   = 1'b1;
      end
      op_addi, op_lw: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
        mem_read  = (opcode == op_lw);
        uses_rs   = 1'b1;
      end
      op_sw: begin
        alu_src   = 1'b1;
        mem_write = 1'b1;
        uses_rs   = 1'b1;
        uses_rt   = 1'b1;
      end
      op_beq, op_bne: begin
        is_beq  = (opcode == op_beq);
        is_bne  = (opcode == op_bne);
        uses_rs = 1'b1;
        uses_rt = 1'b1;
      end
      op_j: jump_taken = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    case (opcode)
      op_sub:  alu_op = alu_sub;
      op_and:  alu_op = alu_and;
      op_or:   alu_op = alu_or;
      op_slt:  alu_op = alu_slt;
      default: alu_op = alu_add;
    endcase
  end

  //////////////////////////////
  // register file
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_n && wb_en && wb_reg != '0) begin
      regs[wb_reg] <= wb_data;
    end
  end

  // r0 reads zero, same-cycle write goes straight through
  function automatic logic [DATA_WIDTH-1:0] read_port(
    input logic [REG_ADDR_WIDTH-1:0] addr,
    input logic [DATA_WIDTH-1:0]     stored,
    input logic                      wr_en,
    input logic [REG_ADDR_WIDTH-1:0] wr_addr,
    input logic [DATA_WIDTH-1:0]     wr_data
  );
    if (addr == '0) begin
      return '0;
    end else if (wr_en && wr_addr == addr) begin
      return wr_data;
    end
    return stored;
  endfunction

  assign rs_data = read_port(rs, regs[rs], wb_en, wb_reg, wb_data);
  assign rt_data = read_port(rt, regs[rt], wb_en, wb_reg, wb_data);

  // load in ID/EX feeding a register this instruction reads
  assign stall = id_ex_mem_read && (id_ex_rt != '0) &&
                 ((uses_rs && id_ex_rt == rs) || (uses_rt && id_ex_rt == rt));

  //////////////////////////////
  // ID/EX register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || stall || flush) begin
      id_ex_reg_write <= 1'b0;
      id_ex_mem_read  <= 1'b0;
      id_ex_mem_write <= 1'b0;
      id_ex_is_beq    <= 1'b0;
      id_ex_is_bne    <= 1'b0;
    end else begin
      id_ex_reg_write <= reg_write;
      id_ex_mem_read  <= mem_read;
      id_ex_mem_write <= mem_write;
      id_ex_is_beq    <= is_beq;
      id_ex_is_bne    <= is_bne;
    end
  end

  always_ff @(posedge clk) begin
    id_ex_rs      <= rs;
    id_ex_rt      <= rt;
    id_ex_rd      <= rd;
    id_ex_rs_data <= rs_data;
    id_ex_rt_data <= rt_data;
    id_ex_imm     <= imm;
    id_ex_alu_op  <= alu_op;
    id_ex_alu_src <= alu_src;
    id_ex_reg_dst <= reg_dst;
  end

  a_no_r0_write_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall |-> !(wb_en && wb_reg == '0));

endmodule

`default_nettype wire

// File: verilog/fetch_stage.sv
`default_nettype none

module fetch_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           stall,
  input  logic                           jump_taken,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0] jump_target,
  input  logic                           flush,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0] branch_target,
  input  logic                           prog_we,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0] prog_addr,
  input  logic [cpu_pkg::INST_WIDTH-1:0] prog_data,
  output logic [cpu_pkg::INST_WIDTH-1:0] if_id_instr,
  output logic [cpu_pkg::ADDR_WIDTH-1:0] if_id_pc
);
  import cpu_pkg::*;

  logic [INST_WIDTH-1:0] imem [IMEM_DEPTH];
  logic [ADDR_WIDTH-1:0] pc;
  logic [ADDR_WIDTH-1:0] pc_next;
  logic [INST_WIDTH-1:0] instr;

  // program load port
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  assign instr = imem[pc];

  // branch redirect wins over everything else
  always_comb begin
    if (flush) begin
      pc_next = branch_target;
    end else if (stall) begin
      pc_next = pc;
    end else if (jump_taken) begin
      pc_next = jump_target;
    end else begin
      pc_next = pc + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // IF/ID, an all-zero word is a nop
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      if_id_instr <= '0;
    end else if (stall) begin
      if_id_instr <= if_id_instr;
    end else if (jump_taken) begin
      if_id_instr <= '0;
    end else begin
      if_id_instr <= instr;
    end
  end

  always_ff @(posedge clk) begin
    if (flush || !stall) begin
      if_id_pc <= pc;
    end
  end

  // program must only be loaded with the core held in reset
  a_load_in_reset: assert property (@(posedge clk) rst_n |-> !prog_we);

endmodule

`default_nettype wire

// File: verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // datapath widths
  localparam int DATA_WIDTH     = 16;
  localparam int INST_WIDTH     = 16;
  localparam int REG_ADDR_WIDTH = 3;
  localparam int IMM_WIDTH      = 6;
  localparam int ADDR_WIDTH     = 6;

  // memory sizes in words
  localparam int IMEM_DEPTH = 64;
  localparam int DMEM_DEPTH = 64;

  // instruction opcodes, bits 15..12
  // codes 12 to 15 are unused and behave as nop
  typedef enum logic [3:0] {
    op_nop  = 4'd0,
    op_add  = 4'd1,
    op_sub  = 4'd2,
    op_and  = 4'd3,
    op_or   = 4'd4,
    op_slt  = 4'd5,
    op_addi = 4'd6,
    op_lw   = 4'd7,
    op_sw   = 4'd8,
    op_beq  = 4'd9,
    op_bne  = 4'd10,
    op_j    = 4'd11
  } opcode_e;

  // alu function select
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_e;

endpackage

`default_nettype wire
